// File: design/spi_regs_pkg.sv
//**************************************************************************
// register numbers and host address map shared by the AVR SPI link
// and the Z80-side bus slave
//**************************************************************************

package spi_regs_pkg;

	localparam int kbd_bits = 40; // full keyboard matrix snapshot

	typedef struct packed {
		logic [3:0] grp; // register group in the high nibble
		logic [3:0] sub; // register within group
	} reg_fields_t;

	// register number shifted in raw and decoded by fields
	typedef union packed {
		logic [7:0]  raw;
		reg_fields_t fld;
	} reg_num_u;

	localparam logic [3:0] grp_kbd   = 4'h1;
	localparam logic [3:0] grp_mouse = 4'h2;
	localparam logic [3:0] grp_rst   = 4'h3;
	localparam logic [3:0] grp_wait  = 4'h4;
	localparam logic [3:0] grp_cfg   = 4'h5;

	localparam logic [3:0] adr_kbd0   = 4'd0; // LSB byte of the keyboard
	localparam logic [3:0] adr_kbd1   = 4'd1;
	localparam logic [3:0] adr_kbd2   = 4'd2;
	localparam logic [3:0] adr_kbd3   = 4'd3;
	localparam logic [3:0] adr_kbd4   = 4'd4;
	localparam logic [3:0] adr_musx   = 4'd5;
	localparam logic [3:0] adr_musy   = 4'd6;
	localparam logic [3:0] adr_musbtn = 4'd7;
	localparam logic [3:0] adr_cfg0   = 4'd8;
	localparam logic [3:0] adr_wait   = 4'd9;
	localparam logic [3:0] adr_status = 4'd10;
	localparam logic [3:0] adr_kj     = 4'd11;

endpackage

// File: design/spi_sync.sv
//**************************************************************************
// brings the AVR SPI pins into the fclk domain and makes edge pulses
//**************************************************************************

module spi_sync (
	input  logic fclk,
	input  logic rst_n,
	input  logic spics_n,
	input  logic spick,
	input  logic spido,
	output logic scs_n,
	output logic sdo,
	output logic cs_rise,
	output logic cs_fall,
	output logic sck_rise
);

	logic [2:0] cs_sync;
	logic [2:0] sck_sync;
	logic [1:0] do_sync;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cs_sync  <= 3'b111; // deselected
			sck_sync <= 3'b000; // clock idles low
			do_sync  <= 2'b00;
		end
		else
		begin
			cs_sync  <= {cs_sync[1:0], spics_n};
			sck_sync <= {sck_sync[1:0], spick};
			do_sync  <= {do_sync[0], spido};
		end
	end

	// stage 1 is the settled level, stage 2 the one before it
	assign scs_n = cs_sync[1];
	assign sdo   = do_sync[1]; // lines up with sck_rise

	assign cs_rise  =  cs_sync[1] & ~cs_sync[2];
	assign cs_fall  = ~cs_sync[1] &  cs_sync[2];
	assign sck_rise = sck_sync[1] & ~sck_sync[2];

endmodule

// File: design/slave_spi.sv
//**************************************************************************
// AVR-facing register file that takes the register number with CS high,
// then data bytes with CS low, and fires strobes when CS rises again
//**************************************************************************

module slave_spi (
	input  logic                              fclk,
	input  logic                              rst_n,
	input  logic                              scs_n,
	input  logic                              sdo,
	input  logic                              cs_rise,
	input  logic                              cs_fall,
	input  logic                              sck_rise,
	input  logic [7:0]                        status,
	input  logic [7:0]                        wait_write,
	output logic                              spidi,
	output logic [spi_regs_pkg::kbd_bits-1:0] kbd_out,
	output logic                              kbd_stb,
	output logic [7:0]                        mus_out,
	output logic                              mus_xstb,
	output logic                              mus_ystb,
	output logic                              mus_btnstb,
	output logic                              kj_stb,
	output logic [7:0]                        config0,
	output logic                              genrst,
	output logic [1:0]                        rstrom,
	output logic [7:0]                        wait_read,
	output logic                              wait_end
);

	import spi_regs_pkg::*;

	reg_num_u            regnum;     // number of the selected register
	logic [7:0]          shift_out;  // byte going back to the AVR
	logic [7:0]          load_data;
	logic [kbd_bits-1:0] kbd_reg;
	logic [7:0]          mouse_buf;  // shared by x, y, buttons, joystick
	logic [7:0]          rst_reg;
	logic [7:0]          wait_reg;
	logic [7:0]          cfg_shadow; // filled bit by bit
	logic [7:0]          cfg_reg;    // what the system sees
	logic                data_bit;   // one data bit arrives

	logic sel_kbdreg, sel_kbdstb;
	logic sel_musx, sel_musy, sel_musbtn, sel_kj, sel_mouse;
	logic sel_rst, sel_wait, sel_cfg;

	assign sel_kbdreg = (regnum.fld.grp == grp_kbd) && !regnum.fld.sub[0]; // $10
	assign sel_kbdstb = (regnum.fld.grp == grp_kbd) &&  regnum.fld.sub[0]; // $11

	assign sel_mouse  = (regnum.fld.grp == grp_mouse);
	assign sel_musx   = sel_mouse && (regnum.fld.sub[1:0] == 2'd0);
	assign sel_musy   = sel_mouse && (regnum.fld.sub[1:0] == 2'd1);
	assign sel_musbtn = sel_mouse && (regnum.fld.sub[1:0] == 2'd2);
	assign sel_kj     = sel_mouse && (regnum.fld.sub[1:0] == 2'd3);

	assign sel_rst  = (regnum.fld.grp == grp_rst);
	assign sel_wait = (regnum.fld.grp == grp_wait);
	assign sel_cfg  = (regnum.fld.grp == grp_cfg);

	assign data_bit  = !scs_n && sck_rise;
	assign load_data = sel_wait ? wait_write : 8'hff;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			regnum.raw <= 8'h00;
			shift_out  <= 8'h00;
			kbd_reg    <= '0;
			mouse_buf  <= 8'h00;
			rst_reg    <= 8'h00;
			wait_reg   <= 8'h00;
			cfg_shadow <= 8'h00;
			cfg_reg    <= 8'h00;
		end
		else
		begin
			// number shifts in LSB first while deselected
			if (cs_rise)
				regnum.raw <= 8'h00;
			else if (scs_n && sck_rise)
				regnum.raw <= {sdo, regnum.raw[7:1]};

			// status while the number goes in, data byte afterwards
			if (cs_rise || cs_fall)
				shift_out <= scs_n ? status : load_data;
			else if (sck_rise)
				shift_out <= {1'b0, shift_out[7:1]};

			if (data_bit && sel_kbdreg)
				kbd_reg <= {sdo, kbd_reg[kbd_bits-1:1]};
			if (data_bit && sel_mouse)
				mouse_buf <= {sdo, mouse_buf[7:1]};
			if (data_bit && sel_rst)
				rst_reg <= {sdo, rst_reg[7:1]};
			if (data_bit && sel_wait)
				wait_reg <= {sdo, wait_reg[7:1]};
			if (data_bit && sel_cfg)
				cfg_shadow <= {sdo, cfg_shadow[7:1]};

			if (cs_rise && sel_cfg)
				cfg_reg <= cfg_shadow; // takes effect at end of transfer
		end
	end

	assign spidi = shift_out[0];

	// strobes use the number of the transfer that is ending
	assign kbd_out = kbd_reg;
	assign kbd_stb = sel_kbdstb && cs_rise;

	assign mus_out    = mouse_buf;
	assign mus_xstb   = sel_musx   && cs_rise;
	assign mus_ystb   = sel_musy   && cs_rise;
	assign mus_btnstb = sel_musbtn && cs_rise;
	assign kj_stb     = sel_kj     && cs_rise;

	assign genrst = sel_rst && cs_rise; // one pulse per $30 write
	assign rstrom = rst_reg[5:4];

	assign wait_read = wait_reg;
	assign wait_end  = sel_wait && cs_rise;

	assign config0 = cfg_reg;

endmodule

// File: design/host_bus.sv
//**************************************************************************
// Z80-side Wishbone classic slave that holds the AVR's keyboard, mouse and
// config data for reading and stalls wait-port cycles for the AVR
//**************************************************************************

module host_bus (
	input  logic                              fclk,
	input  logic                              rst_n,
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  logic [3:0]                        wb_adr,
	input  logic [7:0]                        wb_dat_i,
	output logic                              wb_ack,
	output logic [7:0]                        wb_dat_o,
	input  logic [spi_regs_pkg::kbd_bits-1:0] kbd_out,
	input  logic                              kbd_stb,
	input  logic [7:0]                        mus_out,
	input  logic                              mus_xstb,
	input  logic                              mus_ystb,
	input  logic                              mus_btnstb,
	input  logic                              kj_stb,
	input  logic [7:0]                        config0,
	input  logic [7:0]                        wait_read,
	input  logic                              wait_end,
	output logic [7:0]                        status,
	output logic [7:0]                        wait_write,
	output logic                              wait_pending
);

	import spi_regs_pkg::*;

	logic [kbd_bits-1:0] kbd_lat; // snapshot taken on $11
	logic [7:0]          mus_x;
	logic [7:0]          mus_y;
	logic [7:0]          mus_btn;
	logic [7:0]          kj_reg;
	logic                served;  // AVR has answered this wait cycle
	logic                req;
	logic                is_wait;

	assign req     = wb_cyc && wb_stb;
	assign is_wait = (wb_adr == adr_wait);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			kbd_lat      <= '0;
			mus_x        <= 8'h00;
			mus_y        <= 8'h00;
			mus_btn      <= 8'h00;
			kj_reg       <= 8'h00;
			status       <= 8'h00;
			wait_write   <= 8'h00;
			wait_pending <= 1'b0;
			served       <= 1'b0;
			wb_ack       <= 1'b0;
		end
		else
		begin
			if (kbd_stb)
				kbd_lat <= kbd_out;
			if (mus_xstb)
				mus_x <= mus_out;
			if (mus_ystb)
				mus_y <= mus_out;
			if (mus_btnstb)
				mus_btn <= mus_out;
			if (kj_stb)
				kj_reg <= mus_out;

			if (req && wb_we && wb_adr == adr_status)
				status <= wb_dat_i;

			// wait port raises pending once per cycle until the AVR serves $40
			if (!req)
			begin
				wait_pending <= 1'b0;
				served       <= 1'b0;
			end
			else if (is_wait && !wait_pending && !served)
			begin
				wait_pending <= 1'b1;
				if (wb_we)
					wait_write <= wb_dat_i;
			end
			else if (wait_pending && wait_end)
			begin
				wait_pending <= 1'b0;
				served       <= 1'b1;
			end

			wb_ack <= req && (!is_wait || served || (wait_pending && wait_end));
		end
	end

	always_comb
	begin
		case (wb_adr)
			adr_kbd0:   wb_dat_o = kbd_lat[7:0];
			adr_kbd1:   wb_dat_o = kbd_lat[15:8];
			adr_kbd2:   wb_dat_o = kbd_lat[23:16];
			adr_kbd3:   wb_dat_o = kbd_lat[31:24];
			adr_kbd4:   wb_dat_o = kbd_lat[39:32];
			adr_musx:   wb_dat_o = mus_x;
			adr_musy:   wb_dat_o = mus_y;
			adr_musbtn: wb_dat_o = mus_btn;
			adr_cfg0:   wb_dat_o = config0;
			adr_wait:   wb_dat_o = wait_read; // byte left by the AVR
			adr_status: wb_dat_o = status;
			adr_kj:     wb_dat_o = kj_reg;
			default:    wb_dat_o = 8'hff;
		endcase
	end

endmodule

// File: design/spi_link_top.sv
//**************************************************************************
// AVR-to-FPGA register link between the SPI pins and the Z80 Wishbone bus
//**************************************************************************

module spi_link_top (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       spics_n,
	input  logic       spick,
	input  logic       spido,
	output logic       spidi,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  logic [3:0] wb_adr,
	input  logic [7:0] wb_dat_i,
	output logic       wb_ack,
	output logic [7:0] wb_dat_o,
	output logic       genrst,
	output logic [1:0] rstrom,
	output logic       wait_pending
);

	import spi_regs_pkg::*;

	logic                scs_n, sdo, cs_rise, cs_fall, sck_rise;
	logic [kbd_bits-1:0] kbd_out;
	logic                kbd_stb;
	logic [7:0]          mus_out;
	logic                mus_xstb, mus_ystb, mus_btnstb, kj_stb;
	logic [7:0]          config0;
	logic [7:0]          status;
	logic [7:0]          wait_write;
	logic [7:0]          wait_read;
	logic                wait_end;

	spi_sync u_sync (
		.fclk, .rst_n, .spics_n, .spick, .spido,
		.scs_n, .sdo, .cs_rise, .cs_fall, .sck_rise
	);

	slave_spi u_slave (
		.fclk, .rst_n, .scs_n, .sdo, .cs_rise, .cs_fall, .sck_rise,
		.status, .wait_write, .spidi, .kbd_out, .kbd_stb,
		.mus_out, .mus_xstb, .mus_ystb, .mus_btnstb, .kj_stb,
		.config0, .genrst, .rstrom, .wait_read, .wait_end
	);

	host_bus u_host (
		.fclk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i,
		.wb_ack, .wb_dat_o, .kbd_out, .kbd_stb,
		.mus_out, .mus_xstb, .mus_ystb, .mus_btnstb, .kj_stb,
		.config0, .wait_read, .wait_end, .status, .wait_write, .wait_pending
	);

endmodule

// File: verification/tb_checker.sv
//**************************************************************************
// watches the SPI link ports, keeps a model of the host registers and
// compares every Wishbone read, MISO capture and reset output with it
//**************************************************************************

module tb_checker (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        spics_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [3:0]  wb_adr,
	input  logic [7:0]  wb_dat_i,
	input  logic [7:0]  wb_dat_o,
	input  logic        wb_ack,
	input  logic        genrst,
	input  logic [1:0]  rstrom,
	input  logic        wait_pending,
	input  logic        ev_valid,
	input  logic [1:0]  ev_kind,   // 0 avr write, 1 status byte, 2 wait byte, 3 pending
	input  logic [7:0]  ev_regnum,
	input  logic [39:0] ev_data,
	input  logic        test_end,
	input  int          test_num,
	input  logic        all_done,
	output int          err_total
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [135:0] state;       // keyboard shadow over 12 host bytes
	logic [7:0]   exp_status;  // status seen by the AVR at the last CS rise
	logic [7:0]   exp_wait_wr;
	logic [1:0]   exp_rstrom;
	int           exp_pulses;
	int           got_pulses;
	logic         pend_valid;
	logic [7:0]   pend_rn;
	logic [39:0]  pend_data;
	logic         cs_q;
	logic [3:0]   last_adr;
	logic         last_we;
	logic [7:0]   last_dat;
	int           test_errs;
	int           tests_run;
	int           tests_ok;

	// expected host registers after an AVR write has finished
	function automatic logic [135:0] apply_write(input logic [135:0] st,
		input logic [7:0] rn, input logic [39:0] d);
		case (rn[7:4])
			4'h1:
				if (rn[0])
					st[39:0] = st[135:96]; // snapshot on $11
				else
					st[135:96] = d;
			4'h2:
				case (rn[1:0])
					2'd0: st[47:40] = d[7:0];
					2'd1: st[55:48] = d[7:0];
					2'd2: st[63:56] = d[7:0];
					default: st[95:88] = d[7:0]; // joystick at 11
				endcase
			4'h4: st[79:72] = d[7:0];
			4'h5: st[71:64] = d[7:0];
			default: ;
		endcase
		return st;
	endfunction

	task automatic compare(input string sig, input logic [7:0] e, input logic [7:0] g);
		if (e !== g)
		begin
			$display("** Error %s exp %h got %h", sig, e, g);
			test_errs++;
			err_total++;
		end
	endtask

	always @(posedge fclk)
	begin
		if (!rst_n)
		begin
			state       = '0;
			exp_status  = 8'h00;
			exp_wait_wr = 8'h00;
			exp_rstrom  = 2'b00;
			exp_pulses  = 0;
			got_pulses  = 0;
			pend_valid  = 1'b0;
			cs_q        = 1'b1;
			last_we     = 1'b0;
			last_adr    = 4'h0;
			last_dat    = 8'h00;
		end
		else
		begin
			if (genrst)
				got_pulses++;
			if (wb_ack && !last_we)
				compare("wb_dat_o", state[int'(last_adr)*8 +: 8], wb_dat_o);
			if (wb_ack && last_we && last_adr == 4'd10)
				state[87:80] = last_dat;
			if (wb_cyc && wb_stb)
			begin
				last_adr = wb_adr;
				last_we  = wb_we;
				last_dat = wb_dat_i;
				if (wb_we && wb_adr == 4'd9)
					exp_wait_wr = wb_dat_i;
			end

			if (ev_valid)
				case (ev_kind)
					2'd0:
					begin
						pend_valid = 1'b1;
						pend_rn    = ev_regnum;
						pend_data  = ev_data;
					end
					2'd1: compare("spidi", exp_status, ev_data[7:0]);
					2'd2: compare("spidi", exp_wait_wr, ev_data[7:0]);
					default: compare("wait_pending", {7'b0, ev_data[0]}, {7'b0, wait_pending});
				endcase

			// the write lands when chip select rises
			if (!cs_q && spics_n)
			begin
				exp_status = state[87:80];
				if (pend_valid)
				begin
					state = apply_write(state, pend_rn, pend_data);
					if (pend_rn[7:4] == 4'h3)
					begin
						exp_rstrom = pend_data[5:4];
						exp_pulses++;
					end
				end
				pend_valid = 1'b0;
			end
			cs_q = spics_n;
		end

		if (test_end)
		begin
			if (got_pulses != exp_pulses)
			begin
				$display("** Error genrst pulses exp %h got %h", exp_pulses, got_pulses);
				test_errs++;
				err_total++;
			end
			compare("rstrom", {6'b0, exp_rstrom}, {6'b0, rstrom});
			tests_run++;
			if (test_errs == 0)
			begin
				tests_ok++;
				$display("test %0d: ok", test_num);
			end
			else
				$display("test %0d: %0d errors", test_num, test_errs);
			test_errs = 0;
		end

		if (all_done)
			$display("%0d tests, %0d passed, %0d failed, %0d errors",
				tests_run, tests_ok, tests_run - tests_ok, err_total);
	end

	initial
	begin
		err_total = 0;
		test_errs = 0;
		tests_run = 0;
		tests_ok  = 0;
	end

endmodule

// File: verification/tb_top.sv
//**************************************************************************
// testbench top that acts as the AVR SPI master and the Z80 bus master
// and hands expected events to the checker
//**************************************************************************

module tb_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int spi_bytes = 27; // bytes sent over all tests
	localparam int byte_ns   = 400;

	logic        fclk, rst_n;
	logic        spics_n, spick, spido, spidi;
	logic        wb_cyc, wb_stb, wb_we, wb_ack;
	logic [3:0]  wb_adr;
	logic [7:0]  wb_dat_i, wb_dat_o;
	logic        genrst, wait_pending;
	logic [1:0]  rstrom;
	logic        ev_valid;
	logic [1:0]  ev_kind;
	logic [7:0]  ev_regnum;
	logic [39:0] ev_data;
	logic        test_end, all_done;
	int          test_num;
	int          err_total;
	logic [31:0] seed;
	logic [7:0]  miso_data; // first data byte seen on MISO

	spi_link_top uut (
		.fclk, .rst_n, .spics_n, .spick, .spido, .spidi,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_ack, .wb_dat_o,
		.genrst, .rstrom, .wait_pending
	);

	tb_checker u_check (
		.fclk, .rst_n, .spics_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i,
		.wb_dat_o, .wb_ack, .genrst, .rstrom, .wait_pending,
		.ev_valid, .ev_kind, .ev_regnum, .ev_data, .test_end, .test_num,
		.all_done, .err_total
	);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	initial
	begin
		#(spi_bytes * byte_ns * 2);
		$display("watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		seed = xorshift(seed);
		b = seed[7:0];
	endtask

	task automatic tick(input int n); // inputs change 1 ns past the edge
		repeat (n) @(posedge fclk);
		#1;
	endtask

	task automatic post_event(input logic [1:0] kind, input logic [7:0] rn,
		input logic [39:0] d);
		ev_valid  = 1'b1;
		ev_kind   = kind;
		ev_regnum = rn;
		ev_data   = d;
		tick(1);
		ev_valid = 1'b0;
	endtask

	task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 0; i < 8; i++)
		begin
			spido = tx[i];
			tick(6);
			spick = 1'b1;
			rx[i] = spidi; // MISO taken at the rising edge
			tick(6);
			spick = 1'b0;
		end
	endtask

	task automatic spi_open(input logic [7:0] rn, input int n, input logic [39:0] d);
		logic [7:0] cap;
		spi_byte(rn, cap);
		post_event(2'd1, rn, {32'b0, cap});
		tick(6);
		spics_n = 1'b0;
		tick(6);
		for (int k = 0; k < n; k++)
		begin
			spi_byte(d[8*k +: 8], cap);
			if (k == 0)
				miso_data = cap;
		end
		tick(6);
	endtask

	task automatic spi_close(input logic [7:0] rn, input logic [39:0] d);
		post_event(2'd0, rn, d);
		spics_n = 1'b1;
		tick(10);
	endtask

	task automatic spi_xfer(input logic [7:0] rn, input int n, input logic [39:0] d);
		spi_open(rn, n, d);
		spi_close(rn, d);
	endtask

	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [7:0] din);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_i = din;
		tick(1);
		while (!wb_ack)
			tick(1);
		wb_cyc = 1'b0; // address stays put until the next access
		wb_stb = 1'b0;
		tick(1);
	endtask

	task automatic finish_test(input int n);
		test_num = n;
		test_end = 1'b1;
		tick(1);
		test_end = 1'b0;
	endtask

	initial
	begin
		logic [39:0] kd;
		logic [7:0]  b, w;
		rst_n = 1'b0;
		spics_n = 1'b1;
		spick = 1'b0;
		spido = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 4'h0;
		wb_dat_i = 8'h00;
		ev_valid = 1'b0;
		ev_kind = 2'd0;
		ev_regnum = 8'h00;
		ev_data = '0;
		test_end = 1'b0;
		all_done = 1'b0;
		test_num = 0;
		miso_data = 8'h00;
		seed = 32'hec9f49ae;
		tick(8);
		rst_n = 1'b1;
		tick(2);

		wb_access(1'b0, 4'd8, 8'h00); // reset state
		wb_access(1'b0, 4'd10, 8'h00);
		finish_test(6);

		for (int k = 0; k < 5; k++)
		begin
			rand_byte(b);
			kd[8*k +: 8] = b;
		end
		spi_xfer(8'h10, 5, kd);
		spi_xfer(8'h11, 0, '0);
		for (int a = 0; a < 5; a++)
			wb_access(1'b0, 4'(a), 8'h00);
		finish_test(1);

		for (int k = 0; k < 4; k++)
		begin
			rand_byte(b);
			spi_xfer(8'h20 + 8'(k), 1, {32'b0, b});
		end
		wb_access(1'b0, 4'd5, 8'h00);
		wb_access(1'b0, 4'd6, 8'h00);
		wb_access(1'b0, 4'd7, 8'h00);
		wb_access(1'b0, 4'd11, 8'h00);
		finish_test(2);

		rand_byte(b);
		spi_open(8'h50, 1, {32'b0, b});
		wb_access(1'b0, 4'd8, 8'h00); // still the old config
		spi_close(8'h50, {32'b0, b});
		wb_access(1'b0, 4'd8, 8'h00);
		rand_byte(b);
		spi_xfer(8'h30, 1, {32'b0, b});
		finish_test(3);

		rand_byte(b);
		wb_access(1'b1, 4'd10, b);
		rand_byte(w);
		spi_xfer(8'h22, 1, {32'b0, w});
		spi_xfer(8'h21, 1, {32'b0, w}); // this one sees the new status
		wb_access(1'b0, 4'd10, 8'h00);
		finish_test(4);

		rand_byte(w);
		rand_byte(b);
		fork
			wb_access(1'b1, 4'd9, w);
			begin
				tick(4);
				post_event(2'd3, 8'h00, 40'd1);
				spi_xfer(8'h40, 1, {32'b0, b});
				post_event(2'd2, 8'h40, {32'b0, miso_data});
			end
		join
		post_event(2'd3, 8'h00, 40'd0);
		rand_byte(b);
		fork
			wb_access(1'b0, 4'd9, 8'h00);
			begin
				tick(4);
				spi_xfer(8'h40, 1, {32'b0, b});
				post_event(2'd2, 8'h40, {32'b0, miso_data});
			end
		join
		finish_test(5);

		all_done = 1'b1;
		tick(1);
		all_done = 1'b0;
		if (err_total == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: tb.f
design/spi_regs_pkg.sv
design/spi_sync.sv
design/slave_spi.sv
design/host_bus.sv
design/spi_link_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: Makefile
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: obj_dir/Vtb_top

obj_dir/Vtb_top: $(SRCS) tb.f
	verilator --binary --timing --top-module tb_top -f tb.f -o Vtb_top

# pass only when the testbench prints its pass line
run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
